// ==== tomasulo_slice.f ====
rtl/ooo_pkg.sv
rtl/issue_decode.sv
rtl/regfile_writeback.sv
rtl/rs_bank.sv
rtl/alu_execute.sv
rtl/tomasulo_slice.sv
verif/tb_tomasulo_slice.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f tomasulo_slice.f --top-module tb_tomasulo_slice -o sim_tomasulo_slice &&
./obj_dir/sim_tomasulo_slice | tee /dev/stderr | grep -qxF '>>> PASS' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== verif/tb_tomasulo_slice.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the Tomasulo slice
// Directed tests checked against an in-order model
// ~~~~~~~~~~~~~~~~~~~~

module tb_tomasulo_slice;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_W = 16;
    localparam int NUM_RS = 4;
    localparam int TAG_W  = $clog2(NUM_RS + 1);
    localparam int REG_W  = ooo_pkg::REG_W;

    logic                 clk;
    logic                 reset;
    logic                 flush;
    logic                 instr_valid;
    ooo_pkg::instr_word_u instr;
    logic                 issue_stall;
    logic                 issue_accept;
    logic [TAG_W-1:0]     issue_tag;
    logic                 cdb_valid;
    logic [TAG_W-1:0]     cdb_tag;
    logic [DATA_W-1:0]    cdb_value;
    logic [REG_W-1:0]     cdb_rd;

    tomasulo_slice #(.DATA_W(DATA_W), .NUM_RS(NUM_RS)) u_tomasulo_slice (
        .clk, .reset, .flush, .instr_valid, .instr,
        .issue_stall, .issue_accept, .issue_tag,
        .cdb_valid, .cdb_tag, .cdb_value, .cdb_rd
    );

    // In-order model state and results expected per tag
    logic [DATA_W-1:0] model_reg [ooo_pkg::NUM_REGS];
    logic [DATA_W-1:0] exp_val   [2**TAG_W];
    logic [REG_W-1:0]  exp_rd    [2**TAG_W];
    int                issue_cyc [2**TAG_W];
    logic              pend      [2**TAG_W];
    int pend_cnt = 0;
    int issued   = 0;
    int cyc      = 0;
    int errors   = 0;
    int n_checks = 0;
    logic check_latency = 1'b0;
    logic saw_stall = 1'b0;
    logic [TAG_W-1:0] last_tag;
    logic [31:0] rng = 32'h59eae190;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc > 8 * issued + 200) begin
            $display("Timeout after %0d cycles with %0d results outstanding", cyc, pend_cnt);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [5:0] rand_imm();
        rng = xorshift(rng);
        return rng[5:0];
    endfunction

    function automatic logic [DATA_W-1:0] sext6(input logic [5:0] v);
        return {{(DATA_W - 6){v[5]}}, v};
    endfunction

    // Reference arithmetic with SLT as an offset-binary compare
    function automatic logic [DATA_W-1:0] ref_alu(input ooo_pkg::alu_op_e op,
                                                   input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] bias;
        bias = {1'b1, {(DATA_W - 1){1'b0}}};
        case (op)
            ooo_pkg::ALU_ADD: return a + b;
            ooo_pkg::ALU_SUB: return a + ~b + 1'b1;
            ooo_pkg::ALU_AND: return a & b;
            ooo_pkg::ALU_OR:  return a | b;
            ooo_pkg::ALU_XOR: return a ^ b;
            ooo_pkg::ALU_SLT: return ((a ^ bias) < (b ^ bias)) ? DATA_W'(1) : DATA_W'(0);
            default:          return '0;
        endcase
    endfunction

    function automatic ooo_pkg::instr_word_u make_imm(input ooo_pkg::alu_op_e op,
            input logic [REG_W-1:0] rd, input logic [REG_W-1:0] rs1, input logic [5:0] imm);
        ooo_pkg::instr_word_u w;
        w = '0;
        w.i.imm_form = 1'b1;
        w.i.op  = op;
        w.i.rd  = rd;
        w.i.rs1 = rs1;
        w.i.imm = imm;
        return w;
    endfunction

    function automatic ooo_pkg::instr_word_u make_reg(input ooo_pkg::alu_op_e op,
            input logic [REG_W-1:0] rd, input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2);
        ooo_pkg::instr_word_u w;
        w = '0;
        w.r.op  = op;
        w.r.rd  = rd;
        w.r.rs1 = rs1;
        w.r.rs2 = rs2;
        return w;
    endfunction

    task automatic match_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic reg_idx_match(input string name, input logic [REG_W-1:0] got,
                                 input logic [REG_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic tag_match(input string name, input logic [TAG_W-1:0] got,
                             input logic [TAG_W-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic flag_match(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Every CDB pulse must belong to one pending instruction
    always @(negedge clk) begin
        if (!reset && cdb_valid) begin
            if (!pend[cdb_tag]) begin
                errors++;
                $display("CDB broadcast on tag %0d with no instruction pending", cdb_tag);
            end else begin
                match_data("cdb_value", cdb_value, exp_val[cdb_tag]);
                reg_idx_match("cdb_rd", cdb_rd, exp_rd[cdb_tag]);
                if (check_latency && cyc - issue_cyc[cdb_tag] != 2) begin
                    errors++;
                    $display("Result for tag %0d arrived %0d edges after acceptance, not 2",
                             cdb_tag, cyc - issue_cyc[cdb_tag]);
                end
                pend[cdb_tag] = 1'b0;
                pend_cnt--;
            end
        end
    end

    // Present one word until accepted and record its model result
    task automatic issue_instr(input ooo_pkg::instr_word_u w);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] v;
        @(negedge clk);
        instr_valid = 1'b1;
        instr = w;
        #1;
        while (!issue_accept) begin
            if (issue_stall)
                saw_stall = 1'b1;
            @(negedge clk);
            #1;
        end
        last_tag = issue_tag;
        a = model_reg[w.r.rs1];
        b = w.r.imm_form ? sext6(w.i.imm) : model_reg[w.r.rs2];
        v = ref_alu(w.r.op, a, b);
        if (pend[last_tag]) begin
            errors++;
            $display("Tag %0d handed out again while its result is still pending", last_tag);
        end
        exp_val[last_tag]   = v;
        exp_rd[last_tag]    = w.r.rd;
        issue_cyc[last_tag] = cyc;
        pend[last_tag]      = 1'b1;
        pend_cnt++;
        issued++;
        model_reg[w.r.rd] = v;
        @(posedge clk);
    endtask

    task automatic drain();
        @(negedge clk);
        instr_valid = 1'b0;
        #1;
        while (pend_cnt != 0) begin
            @(negedge clk);
            #1;
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished, errors so far %0d", name, errors);
    endtask

    task automatic reset_and_imm_ops();
        @(negedge clk);
        flag_match("issue_stall", issue_stall, 1'b0);
        flag_match("issue_accept", issue_accept, 1'b0);
        flag_match("cdb_valid", cdb_valid, 1'b0);
        tag_match("issue_tag", issue_tag, TAG_W'(1));
        check_latency = 1'b1;
        for (int k = 0; k < 6; k++) begin
            issue_instr(make_imm(ooo_pkg::alu_op_e'(k), REG_W'(k + 1), '0, rand_imm()));
            drain();
        end
        check_latency = 1'b0;
        report_test("reset and immediate ops");
    endtask

    task automatic reg_form_ops();
        issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd1, 3'd0, 6'h3b));
        issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd2, 3'd0, rand_imm()));
        issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd3, 3'd0, 6'h1f));
        drain();
        for (int k = 0; k < 6; k++)
            issue_instr(make_reg(ooo_pkg::alu_op_e'(k), REG_W'(4 + k % 4),
                                 REG_W'(1 + k % 3), REG_W'(1 + (k + 1) % 3)));
        // Negative operands on both sides of SLT
        issue_instr(make_reg(ooo_pkg::ALU_SLT, 3'd7, 3'd2, 3'd1));
        issue_instr(make_reg(ooo_pkg::ALU_SLT, 3'd6, 3'd1, 3'd0));
        drain();
        report_test("register form");
    endtask

    task automatic dependency_chain();
        issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd3, 3'd0, rand_imm()));
        // One idle cycle puts the next read on the producer's CDB cycle
        @(negedge clk);
        instr_valid = 1'b0;
        for (int k = 0; k < 6; k++) begin
            if (k % 2 == 0)
                issue_instr(make_reg(ooo_pkg::alu_op_e'(k), 3'd3, 3'd3, 3'd2));
            else
                issue_instr(make_imm(ooo_pkg::alu_op_e'(k), 3'd3, 3'd3, rand_imm()));
        end
        drain();
        report_test("dependency chain");
    endtask

    // A long chain drains slower than it issues and fills the stations
    task automatic stall_on_full();
        saw_stall = 1'b0;
        issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd5, 3'd0, 6'h01));
        for (int k = 0; k < 10; k++)
            issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd5, 3'd5, rand_imm()));
        drain();
        n_checks++;
        if (!saw_stall) begin
            errors++;
            $display("issue_stall never rose while the stations were full");
        end
        flag_match("issue_stall", issue_stall, 1'b0);
        report_test("stall on full stations");
    endtask

    task automatic write_after_write();
        logic [5:0] imm;
        imm = rand_imm();
        // Older writer waits on r3 and broadcasts after the younger one
        issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd3, 3'd0, imm ^ 6'h2a));
        issue_instr(make_reg(ooo_pkg::ALU_ADD, 3'd4, 3'd3, 3'd0));
        issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd4, 3'd0, imm));
        issue_instr(make_reg(ooo_pkg::ALU_ADD, 3'd5, 3'd4, 3'd0));
        drain();
        issue_instr(make_reg(ooo_pkg::ALU_OR, 3'd6, 3'd4, 3'd0));
        drain();
        report_test("write after write");
    endtask

    task automatic flush_in_flight();
        logic [DATA_W-1:0] saved;
        issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd6, 3'd0, 6'h07));
        drain();
        saved = model_reg[6];
        // Seven chained writes to r6 leave every station busy
        issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd6, 3'd0, 6'h09));
        for (int k = 0; k < 6; k++)
            issue_instr(make_imm(ooo_pkg::ALU_ADD, 3'd6, 3'd6, rand_imm()));
        @(negedge clk);
        flag_match("issue_stall", issue_stall, 1'b1);
        flush = 1'b1;
        instr_valid = 1'b0;
        #1;
        // Flushed work must never reach the CDB
        for (int t = 0; t < 2**TAG_W; t++)
            pend[t] = 1'b0;
        pend_cnt = 0;
        model_reg[6] = saved;
        @(negedge clk);
        flush = 1'b0;
        flag_match("issue_stall", issue_stall, 1'b0);
        issue_instr(make_reg(ooo_pkg::ALU_ADD, 3'd7, 3'd6, 3'd0));
        drain();
        report_test("flush in flight");
    endtask

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        for (int r = 0; r < ooo_pkg::NUM_REGS; r++)
            model_reg[r] = '0;
        for (int t = 0; t < 2**TAG_W; t++)
            pend[t] = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        reset_and_imm_ops();
        reg_form_ops();
        dependency_chain();
        stall_on_full();
        write_after_write();
        flush_in_flight();

        $display("Checks %0d, errors %0d, instructions issued %0d", n_checks, errors, issued);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/tomasulo_slice.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~
// Tomasulo issue-to-writeback slice
// Decode, stations, ALU and register file
// ~~~~~~~~~~~~~~~~~~~~

module tomasulo_slice #(
    parameter int DATA_W = 16,
    parameter int NUM_RS = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          instr_valid,
    input  ooo_pkg::instr_word_u          instr,
    output logic                          issue_stall,
    output logic                          issue_accept,
    output logic [$clog2(NUM_RS+1)-1:0]   issue_tag,
    output logic                          cdb_valid,
    output logic [$clog2(NUM_RS+1)-1:0]   cdb_tag,
    output logic [DATA_W-1:0]             cdb_value,
    output logic [ooo_pkg::REG_W-1:0]     cdb_rd
);
    localparam int TAG_W = $clog2(NUM_RS + 1);
    localparam int IDX_W = $clog2(NUM_RS);
    localparam int REG_W = ooo_pkg::REG_W;

    // Register file read port
    logic [REG_W-1:0]  rs1_idx;
    logic [REG_W-1:0]  rs2_idx;
    logic [DATA_W-1:0] rs1_value;
    logic [DATA_W-1:0] rs2_value;
    logic [TAG_W-1:0]  rs1_tag;
    logic [TAG_W-1:0]  rs2_tag;

    // Station write and rename
    logic              alloc_en;
    logic [IDX_W-1:0]  alloc_idx;
    ooo_pkg::alu_op_e  ent_op;
    logic [DATA_W-1:0] ent_vj;
    logic [DATA_W-1:0] ent_vk;
    logic [TAG_W-1:0]  ent_qj;
    logic [TAG_W-1:0]  ent_qk;
    logic [REG_W-1:0]  ent_rd;
    logic              set_en;
    logic [REG_W-1:0]  set_rd;
    logic [TAG_W-1:0]  set_tag;

    // Station state toward the ALU
    logic [NUM_RS-1:0]        busy;
    logic [NUM_RS-1:0]        ready;
    logic [NUM_RS-1:0]        consume;
    logic [NUM_RS*3-1:0]      st_op;
    logic [NUM_RS*DATA_W-1:0] st_vj;
    logic [NUM_RS*DATA_W-1:0] st_vk;
    logic [NUM_RS*REG_W-1:0]  st_rd;

    issue_decode #(.DATA_W(DATA_W), .NUM_RS(NUM_RS)) u_issue_decode (
        .clk, .reset, .instr_valid, .instr, .busy,
        .rs1_value, .rs1_tag, .rs2_value, .rs2_tag,
        .rs1_idx, .rs2_idx, .alloc_en, .alloc_idx,
        .ent_op, .ent_vj, .ent_qj, .ent_vk, .ent_qk, .ent_rd,
        .set_en, .set_rd, .set_tag,
        .issue_stall, .issue_accept, .issue_tag
    );

    regfile_writeback #(.DATA_W(DATA_W), .NUM_RS(NUM_RS)) u_regfile_writeback (
        .clk, .reset, .flush, .rs1_idx, .rs2_idx,
        .set_en, .set_rd, .set_tag,
        .cdb_valid, .cdb_tag, .cdb_value,
        .rs1_value, .rs1_tag, .rs2_value, .rs2_tag
    );

    rs_bank #(.DATA_W(DATA_W), .NUM_RS(NUM_RS)) u_rs_bank (
        .clk, .reset, .flush, .alloc_en, .alloc_idx,
        .ent_op, .ent_vj, .ent_qj, .ent_vk, .ent_qk, .ent_rd,
        .cdb_valid, .cdb_tag, .cdb_value, .consume,
        .busy, .ready, .st_op, .st_vj, .st_vk, .st_rd
    );

    alu_execute #(.DATA_W(DATA_W), .NUM_RS(NUM_RS)) u_alu_execute (
        .clk, .reset, .flush, .ready, .st_op, .st_vj, .st_vk, .st_rd,
        .consume, .cdb_valid, .cdb_tag, .cdb_value, .cdb_rd
    );

endmodule

`default_nettype wire

// ==== rtl/alu_execute.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~
// Single-cycle ALU
// Dispatches the lowest ready station and drives the CDB
// ~~~~~~~~~~~~~~~~~~~~

module alu_execute #(
    parameter int DATA_W = 16,
    parameter int NUM_RS = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                flush,
    input  logic [NUM_RS-1:0]                   ready,
    input  logic [NUM_RS*3-1:0]                 st_op,
    input  logic [NUM_RS*DATA_W-1:0]            st_vj,
    input  logic [NUM_RS*DATA_W-1:0]            st_vk,
    input  logic [NUM_RS*ooo_pkg::REG_W-1:0]    st_rd,
    output logic [NUM_RS-1:0]                   consume,
    output logic                                cdb_valid,
    output logic [$clog2(NUM_RS+1)-1:0]         cdb_tag,
    output logic [DATA_W-1:0]                   cdb_value,
    output logic [ooo_pkg::REG_W-1:0]           cdb_rd
);
    localparam int TAG_W = $clog2(NUM_RS + 1);
    localparam int IDX_W = $clog2(NUM_RS);
    localparam int REG_W = ooo_pkg::REG_W;

    logic [IDX_W-1:0]  sel;
    logic              dispatch;
    ooo_pkg::alu_op_e  op;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] result;

    // Fixed priority, station 0 first
    always_comb begin
        sel = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (ready[i])
                sel = IDX_W'(i);
        end
    end

    assign dispatch = |ready && !flush;
    assign consume  = dispatch ? (NUM_RS'(1) << sel) : '0;

    assign op = ooo_pkg::alu_op_e'(st_op[sel*3 +: 3]);
    assign a  = st_vj[sel*DATA_W +: DATA_W];
    assign b  = st_vk[sel*DATA_W +: DATA_W];

    always_comb begin
        case (op)
            ooo_pkg::ALU_ADD: result = a + b;
            ooo_pkg::ALU_SUB: result = a - b;
            ooo_pkg::ALU_AND: result = a & b;
            ooo_pkg::ALU_OR:  result = a | b;
            ooo_pkg::ALU_XOR: result = a ^ b;
            ooo_pkg::ALU_SLT: result = DATA_W'($signed(a) < $signed(b));
            default:          result = '0;
        endcase
    end

    // One-cycle broadcast, dropped by flush
    always_ff @(posedge clk) begin
        if (reset)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= dispatch;
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            cdb_tag   <= TAG_W'(sel) + TAG_W'(1);
            cdb_value <= result;
            cdb_rd    <= st_rd[sel*REG_W +: REG_W];
        end
    end

    a_consume_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(consume));

endmodule

`default_nettype wire

// ==== rtl/rs_bank.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~
// Reservation station bank
// Holds issued entries until both operands arrive on the CDB
// ~~~~~~~~~~~~~~~~~~~~

module rs_bank #(
    parameter int DATA_W = 16,
    parameter int NUM_RS = 4
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                flush,
    input  logic                                alloc_en,
    input  logic [$clog2(NUM_RS)-1:0]           alloc_idx,
    input  ooo_pkg::alu_op_e                    ent_op,
    input  logic [DATA_W-1:0]                   ent_vj,
    input  logic [$clog2(NUM_RS+1)-1:0]         ent_qj,
    input  logic [DATA_W-1:0]                   ent_vk,
    input  logic [$clog2(NUM_RS+1)-1:0]         ent_qk,
    input  logic [ooo_pkg::REG_W-1:0]           ent_rd,
    input  logic                                cdb_valid,
    input  logic [$clog2(NUM_RS+1)-1:0]         cdb_tag,
    input  logic [DATA_W-1:0]                   cdb_value,
    input  logic [NUM_RS-1:0]                   consume,
    output logic [NUM_RS-1:0]                   busy,
    output logic [NUM_RS-1:0]                   ready,
    output logic [NUM_RS*3-1:0]                 st_op,
    output logic [NUM_RS*DATA_W-1:0]            st_vj,
    output logic [NUM_RS*DATA_W-1:0]            st_vk,
    output logic [NUM_RS*ooo_pkg::REG_W-1:0]    st_rd
);
    localparam int TAG_W = $clog2(NUM_RS + 1);
    localparam int IDX_W = $clog2(NUM_RS);
    localparam int REG_W = ooo_pkg::REG_W;

    for (genvar s = 0; s < NUM_RS; s++) begin : g_station
        logic              busy_q;
        logic [TAG_W-1:0]  qj_q;
        logic [TAG_W-1:0]  qk_q;
        ooo_pkg::alu_op_e  op_q;
        logic [DATA_W-1:0] vj_q;
        logic [DATA_W-1:0] vk_q;
        logic [REG_W-1:0]  rd_q;
        logic              wr;
        logic              hit_j;
        logic              hit_k;

        assign wr    = alloc_en && alloc_idx == IDX_W'(s);
        assign hit_j = cdb_valid && qj_q != '0 && qj_q == cdb_tag;
        assign hit_k = cdb_valid && qk_q != '0 && qk_q == cdb_tag;

        // Occupancy and pending tags
        always_ff @(posedge clk) begin
            if (reset || flush || consume[s]) begin
                busy_q <= 1'b0;
                qj_q   <= '0;
                qk_q   <= '0;
            end else if (wr) begin
                busy_q <= 1'b1;
                qj_q   <= ent_qj;
                qk_q   <= ent_qk;
            end else begin
                if (hit_j)
                    qj_q <= '0;
                if (hit_k)
                    qk_q <= '0;
            end
        end

        // Operand values, filled at write or from the CDB
        always_ff @(posedge clk) begin
            if (wr) begin
                op_q <= ent_op;
                vj_q <= ent_vj;
                vk_q <= ent_vk;
                rd_q <= ent_rd;
            end else begin
                if (hit_j)
                    vj_q <= cdb_value;
                if (hit_k)
                    vk_q <= cdb_value;
            end
        end

        assign busy[s]  = busy_q;
        assign ready[s] = busy_q && qj_q == '0 && qk_q == '0;
        assign st_op[s*3 +: 3]           = op_q;
        assign st_vj[s*DATA_W +: DATA_W] = vj_q;
        assign st_vk[s*DATA_W +: DATA_W] = vk_q;
        assign st_rd[s*REG_W +: REG_W]   = rd_q;
    end

    // Dispatch may only take stations with both operands present
    a_consume_ready: assert property (@(posedge clk) disable iff (reset)
        (consume & ~ready) == '0);

endmodule

`default_nettype wire

// ==== rtl/regfile_writeback.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~
// Register file with producer tags
// Reads bypass the CDB, results retire by tag
// ~~~~~~~~~~~~~~~~~~~~

module regfile_writeback #(
    parameter int DATA_W = 16,
    parameter int NUM_RS = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic [ooo_pkg::REG_W-1:0]     rs1_idx,
    input  logic [ooo_pkg::REG_W-1:0]     rs2_idx,
    input  logic                          set_en,
    input  logic [ooo_pkg::REG_W-1:0]     set_rd,
    input  logic [$clog2(NUM_RS+1)-1:0]   set_tag,
    input  logic                          cdb_valid,
    input  logic [$clog2(NUM_RS+1)-1:0]   cdb_tag,
    input  logic [DATA_W-1:0]             cdb_value,
    output logic [DATA_W-1:0]             rs1_value,
    output logic [$clog2(NUM_RS+1)-1:0]   rs1_tag,
    output logic [DATA_W-1:0]             rs2_value,
    output logic [$clog2(NUM_RS+1)-1:0]   rs2_tag
);
    localparam int TAG_W = $clog2(NUM_RS + 1);

    logic [DATA_W-1:0] value_q [ooo_pkg::NUM_REGS];
    logic [TAG_W-1:0]  tag_q   [ooo_pkg::NUM_REGS];

    // Operand reads, a result on the CDB this cycle counts as present
    always_comb begin
        rs1_value = value_q[rs1_idx];
        rs1_tag   = tag_q[rs1_idx];
        if (cdb_valid && tag_q[rs1_idx] == cdb_tag) begin
            rs1_value = cdb_value;
            rs1_tag   = '0;
        end
        rs2_value = value_q[rs2_idx];
        rs2_tag   = tag_q[rs2_idx];
        if (cdb_valid && tag_q[rs2_idx] == cdb_tag) begin
            rs2_value = cdb_value;
            rs2_tag   = '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < ooo_pkg::NUM_REGS; r++) begin
            if (reset) begin
                value_q[r] <= '0;
                tag_q[r]   <= '0;
            end else if (flush) begin
                // Values kept, pending producers forgotten
                tag_q[r] <= '0;
            end else begin
                if (cdb_valid && tag_q[r] == cdb_tag)
                    value_q[r] <= cdb_value;
                // New producer from issue beats the retire clear
                if (set_en && set_rd == ooo_pkg::REG_W'(r))
                    tag_q[r] <= set_tag;
                else if (cdb_valid && tag_q[r] == cdb_tag)
                    tag_q[r] <= '0;
            end
        end
    end

    // Tag 0 means no producer, so a broadcast must name a station
    a_cdb_tag_nonzero: assert property (@(posedge clk) disable iff (reset)
        cdb_valid |-> cdb_tag != '0);

endmodule

`default_nettype wire

// ==== rtl/issue_decode.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~
// Issue decode
// Builds a station entry and claims the lowest free station
// ~~~~~~~~~~~~~~~~~~~~

module issue_decode #(
    parameter int DATA_W = 16,
    parameter int NUM_RS = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          instr_valid,
    input  ooo_pkg::instr_word_u          instr,
    input  logic [NUM_RS-1:0]             busy,
    input  logic [DATA_W-1:0]             rs1_value,
    input  logic [$clog2(NUM_RS+1)-1:0]   rs1_tag,
    input  logic [DATA_W-1:0]             rs2_value,
    input  logic [$clog2(NUM_RS+1)-1:0]   rs2_tag,
    output logic [ooo_pkg::REG_W-1:0]     rs1_idx,
    output logic [ooo_pkg::REG_W-1:0]     rs2_idx,
    output logic                          alloc_en,
    output logic [$clog2(NUM_RS)-1:0]     alloc_idx,
    output ooo_pkg::alu_op_e              ent_op,
    output logic [DATA_W-1:0]             ent_vj,
    output logic [$clog2(NUM_RS+1)-1:0]   ent_qj,
    output logic [DATA_W-1:0]             ent_vk,
    output logic [$clog2(NUM_RS+1)-1:0]   ent_qk,
    output logic [ooo_pkg::REG_W-1:0]     ent_rd,
    output logic                          set_en,
    output logic [ooo_pkg::REG_W-1:0]     set_rd,
    output logic [$clog2(NUM_RS+1)-1:0]   set_tag,
    output logic                          issue_stall,
    output logic                          issue_accept,
    output logic [$clog2(NUM_RS+1)-1:0]   issue_tag
);
    localparam int TAG_W = $clog2(NUM_RS + 1);
    localparam int IDX_W = $clog2(NUM_RS);
    localparam int IMM_W = 6;

    // Lowest free station
    always_comb begin
        alloc_idx = '0;
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (!busy[i])
                alloc_idx = IDX_W'(i);
        end
    end

    assign issue_stall  = &busy;
    assign issue_accept = instr_valid && !issue_stall;
    assign issue_tag    = TAG_W'(alloc_idx) + TAG_W'(1);

    assign rs1_idx = instr.r.rs1;
    assign rs2_idx = instr.r.rs2;

    assign alloc_en = issue_accept;
    assign ent_op   = instr.r.op;
    assign ent_rd   = instr.r.rd;
    assign ent_vj   = rs1_value;
    assign ent_qj   = rs1_tag;

    // Immediate form replaces the second source
    always_comb begin
        if (instr.r.imm_form) begin
            ent_vk = {{(DATA_W - IMM_W){instr.i.imm[IMM_W-1]}}, instr.i.imm};
            ent_qk = '0;
        end else begin
            ent_vk = rs2_value;
            ent_qk = rs2_tag;
        end
    end

    // Rename destination to the new station
    assign set_en  = issue_accept;
    assign set_rd  = instr.r.rd;
    assign set_tag = issue_tag;

    // Allocation must land on a free station
    a_alloc_free: assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> !busy[alloc_idx]);

endmodule

`default_nettype wire

// ==== rtl/ooo_pkg.sv ====
`default_nettype none
// ~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the out-of-order slice
// ALU operation codes and the 16-bit instruction word
// ~~~~~~~~~~~~~~~~~~~~

package ooo_pkg;

    // Architectural register file size
    localparam int NUM_REGS = 8;
    localparam int REG_W    = $clog2(NUM_REGS);

    // ALU operations, low three opcode bits
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Register form: rd = rs1 op rs2
    typedef struct packed {
        logic             imm_form;
        alu_op_e          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [2:0]       unused;
    } instr_reg_t;

    // Immediate form: rd = rs1 op sext(imm)
    typedef struct packed {
        logic             imm_form;
        alu_op_e          op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic signed [5:0] imm;
    } instr_imm_t;

    // Top opcode bit picks which view applies
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_word_u;

endpackage

`default_nettype wire
